/* common/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Physical byte address width seen by the core
`define DC_ALEN 43

// One cache word, also the memory bus width
`define DC_DATA_W 64

// Line index width, 256 lines
`define DC_INDEX_W 8

// Byte offset bits dropped from word-aligned addresses
`define DC_ALIGN_W 3

// Word address width on the core and memory sides
`define DC_WADDR_W (`DC_ALEN - `DC_ALIGN_W)

// Tag bits kept next to each word
`define DC_TAG_W (`DC_WADDR_W - `DC_INDEX_W)

`endif

/* common/addr_pkg.sv */
`include "cache_macros.svh"

package addr_pkg;

    // Word address, the byte offset is always zero and is not carried
    typedef logic [`DC_WADDR_W-1:0] aligned_addr_t;

    // Low word-address bits select the line
    typedef logic [`DC_INDEX_W-1:0] index_t;

    // Remaining upper bits identify which word occupies the line
    typedef logic [`DC_TAG_W-1:0] tag_t;

endpackage

/* common/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`DC_DATA_W-1:0] data_t;

    // Stored line entry with the tag in the upper bits and data below it
    typedef logic [$bits(addr_pkg::tag_t)+`DC_DATA_W-1:0] entry_t;

    // Refill controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        RESPOND
    } refill_state_t;

endpackage

/* cache/line_store.sv */
`timescale 1ns/1ps

// Direct-mapped line memory, one word per line
// Entry layout is tag above data, valid bits are held outside the RAM so that
// a flush can clear them all in one cycle
module line_store (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    write_en,
    input  addr_pkg::aligned_addr_t waddr,
    input  cache_pkg::data_t        wdata,
    input  logic                    rd_en,
    input  addr_pkg::aligned_addr_t raddr,
    input  logic                    flush,
    output cache_pkg::data_t        rdata,
    output logic                    lookup_valid
);

    localparam int unsigned INDEX_W = $bits(addr_pkg::index_t);
    localparam int unsigned TAG_W   = $bits(addr_pkg::tag_t);
    localparam int unsigned DATA_W  = $bits(cache_pkg::data_t);
    localparam int unsigned ENTRY_W = $bits(cache_pkg::entry_t);
    localparam int unsigned ADDR_W  = $bits(addr_pkg::aligned_addr_t);
    localparam int unsigned DEPTH   = 1 << INDEX_W;

    // The address split only works if index and tag cover the whole word address
    generate
        if (INDEX_W + TAG_W != ADDR_W) begin : g_addr_split_check
            $error("line_store: index and tag widths do not add up to the address width");
        end
    endgenerate

    addr_pkg::index_t   w_index;
    addr_pkg::tag_t     w_tag;
    addr_pkg::index_t   r_index;
    addr_pkg::tag_t     r_tag;

    cache_pkg::entry_t  mem [DEPTH];
    logic [DEPTH-1:0]   valid_bits;

    cache_pkg::entry_t  rd_entry;
    addr_pkg::tag_t     rd_tag;
    addr_pkg::tag_t     stored_tag;
    logic               rd_valid;

    assign w_index = waddr[INDEX_W-1:0];
    assign w_tag   = waddr[ADDR_W-1 -: TAG_W];
    assign r_index = raddr[INDEX_W-1:0];
    assign r_tag   = raddr[ADDR_W-1 -: TAG_W];

    // Plain write and registered read so the array maps onto block RAM
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[w_index] <= {w_tag, wdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= mem[r_index];
            rd_tag   <= r_tag;
        end
    end

    // Flush wins over a write, though the controller never issues both
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_bits <= '0;
        end else if (write_en) begin
            valid_bits[w_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (rd_en) begin
            rd_valid <= valid_bits[r_index];
        end
    end

    assign stored_tag   = rd_entry[ENTRY_W-1 -: TAG_W];
    assign rdata        = rd_entry[DATA_W-1:0];
    assign lookup_valid = rd_valid && (stored_tag == rd_tag);

endmodule

/* cache/refill_ctrl.sv */
`timescale 1ns/1ps

// Sequences one core request at a time around the line store
// Loads look up the line store and refill from memory on a miss, stores are
// written through to memory and allocated in the same cycle
module refill_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    we,
    input  addr_pkg::aligned_addr_t addr,
    input  cache_pkg::data_t        wdata,
    input  logic                    flush,
    input  logic                    lookup_valid,
    input  cache_pkg::data_t        lookup_data,
    input  logic                    mem_rvalid,
    input  cache_pkg::data_t        mem_rdata,
    output logic                    busy,
    output logic                    resp_valid,
    output cache_pkg::data_t        resp_data,
    output logic                    resp_hit,
    output logic                    store_we,
    output addr_pkg::aligned_addr_t store_waddr,
    output cache_pkg::data_t        store_wdata,
    output logic                    store_rd_en,
    output addr_pkg::aligned_addr_t store_raddr,
    output logic                    store_flush,
    output logic                    mem_req,
    output logic                    mem_we,
    output addr_pkg::aligned_addr_t mem_addr,
    output cache_pkg::data_t        mem_wdata
);

    cache_pkg::refill_state_t state;
    addr_pkg::aligned_addr_t  req_addr;
    logic                     idle;
    logic                     refill_done;

    assign idle        = (state == cache_pkg::IDLE);
    assign refill_done = (state == cache_pkg::MEM_WAIT) && mem_rvalid;

    // New requests only start from IDLE, the core is expected to honour busy
    assign store_rd_en = idle && req && !we;
    assign store_raddr = addr;
    assign store_flush = idle && flush;

    // One write port shared by stores from the core and refills from memory
    assign store_we    = (idle && req && we) || refill_done;
    assign store_waddr = idle ? addr : req_addr;
    assign store_wdata = idle ? wdata : mem_rdata;

    // A store keeps busy up for the single cycle in which mem_we is out
    assign busy = !idle || mem_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= cache_pkg::IDLE;
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
            mem_req    <= 1'b0;
            mem_we     <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            mem_req    <= 1'b0;
            mem_we     <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    if (req && we) begin
                        mem_we <= 1'b1;
                    end else if (req) begin
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (lookup_valid) begin
                        resp_valid <= 1'b1;
                        resp_hit   <= 1'b1;
                        state      <= cache_pkg::RESPOND;
                    end else begin
                        mem_req <= 1'b1;
                        state   <= cache_pkg::MEM_WAIT;
                    end
                end
                cache_pkg::MEM_WAIT: begin
                    // Memory latency is open ended, wait for its data strobe
                    if (mem_rvalid) begin
                        resp_valid <= 1'b1;
                        resp_hit   <= 1'b0;
                        state      <= cache_pkg::RESPOND;
                    end
                end
                cache_pkg::RESPOND: begin
                    state <= cache_pkg::IDLE;
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    // Request address and the memory port address and write data
    always_ff @(posedge clk) begin
        if (idle && req) begin
            req_addr <= addr;
        end
        if (idle && req && we) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end else if ((state == cache_pkg::LOOKUP) && !lookup_valid) begin
            mem_addr <= req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == cache_pkg::LOOKUP) && lookup_valid) begin
            resp_data <= lookup_data;
        end else if (refill_done) begin
            resp_data <= mem_rdata;
        end
    end

endmodule

/* design/dcache_top.sv */
`timescale 1ns/1ps

// Data cache top level, line store with its refill controller
module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    we,
    input  addr_pkg::aligned_addr_t addr,
    input  cache_pkg::data_t        wdata,
    input  logic                    flush,
    output logic                    busy,
    output logic                    resp_valid,
    output cache_pkg::data_t        resp_data,
    output logic                    resp_hit,
    output logic                    mem_req,
    output logic                    mem_we,
    output addr_pkg::aligned_addr_t mem_addr,
    output cache_pkg::data_t        mem_wdata,
    input  logic                    mem_rvalid,
    input  cache_pkg::data_t        mem_rdata
);

    logic                    store_we;
    addr_pkg::aligned_addr_t store_waddr;
    cache_pkg::data_t        store_wdata;
    logic                    store_rd_en;
    addr_pkg::aligned_addr_t store_raddr;
    logic                    store_flush;
    cache_pkg::data_t        store_rdata;
    logic                    lookup_valid;

    line_store line_store_i (
        .clk          (clk),
        .rst          (rst),
        .write_en     (store_we),
        .waddr        (store_waddr),
        .wdata        (store_wdata),
        .rd_en        (store_rd_en),
        .raddr        (store_raddr),
        .flush        (store_flush),
        .rdata        (store_rdata),
        .lookup_valid (lookup_valid)
    );

    refill_ctrl refill_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .flush        (flush),
        .lookup_valid (lookup_valid),
        .lookup_data  (store_rdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .busy         (busy),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .resp_hit     (resp_hit),
        .store_we     (store_we),
        .store_waddr  (store_waddr),
        .store_wdata  (store_wdata),
        .store_rd_en  (store_rd_en),
        .store_raddr  (store_raddr),
        .store_flush  (store_flush),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

// Free running 10 ns clock and a synchronous reset held for the first cycles
module clk_gen #(
    parameter int unsigned RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset drops just after the last reset edge so the DUT sees a clean edge count
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ps

// Backing memory for the cache
// Unwritten words read as their word address XOR a fixed key, writes are kept
// in a log and the newest entry for an address wins
module mem_model #(
    parameter int unsigned LATENCY   = 3,
    parameter int unsigned LOG_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_req,
    input  logic                    mem_we,
    input  addr_pkg::aligned_addr_t mem_addr,
    input  cache_pkg::data_t        mem_wdata,
    output logic                    mem_rvalid,
    output cache_pkg::data_t        mem_rdata
);

    localparam logic [63:0] FILL_KEY = 64'hA5C3_0F1E_96B4_7D28;

    addr_pkg::aligned_addr_t log_addr [LOG_DEPTH];
    cache_pkg::data_t        log_data [LOG_DEPTH];
    int unsigned             log_count;
    addr_pkg::aligned_addr_t rd_addr;
    int unsigned             wait_cnt;
    logic                    pending;

    function automatic cache_pkg::data_t read_word(input addr_pkg::aligned_addr_t a);
        cache_pkg::data_t w;
        w = cache_pkg::data_t'(a) ^ FILL_KEY;
        for (int i = 0; i < log_count; i++) begin
            if (log_addr[i] == a) begin
                w = log_data[i];
            end
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            mem_rvalid <= 1'b0;
            log_count  <= 0;
        end else begin
            mem_rvalid <= 1'b0;
            if (mem_we && log_count < LOG_DEPTH) begin
                log_addr[log_count] <= mem_addr;
                log_data[log_count] <= mem_wdata;
                log_count           <= log_count + 1;
            end
            // Data comes back LATENCY cycles after the cycle holding mem_req
            if (mem_req) begin
                pending  <= 1'b1;
                rd_addr  <= mem_addr;
                wait_cnt <= LATENCY - 1;
            end else if (pending && wait_cnt == 1) begin
                pending    <= 1'b0;
                mem_rvalid <= 1'b1;
                mem_rdata  <= read_word(rd_addr);
            end else if (pending) begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

/* bench/dcache_properties.sv */
`timescale 1ns/1ps

// Protocol checks on the cache top level ports
module dcache_properties (
    input logic clk,
    input logic rst,
    input logic req,
    input logic busy,
    input logic resp_valid,
    input logic mem_req,
    input logic mem_rvalid
);

    // Delayed reset so that the very first edge, before any reset took effect, is skipped
    logic in_reset_q;

    always @(posedge clk) begin
        in_reset_q <= rst;
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst && in_reset_q |-> !resp_valid && !mem_req)
        else $error("resp_valid or mem_req active during reset");

    no_req_when_busy: assert property (@(posedge clk) disable iff (rst)
        req |-> !busy)
        else $error("req strobed while busy is high");

    mem_req_single: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req)
        else $error("mem_req held for more than one cycle");

    // A refill always ends with a load response right after the memory data
    refill_answered: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> mem_rvalid [->1] ##1 resp_valid)
        else $error("no resp_valid in the cycle after mem_rvalid");

endmodule

bind dcache_top dcache_properties dcache_properties_i (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .busy       (busy),
    .resp_valid (resp_valid),
    .mem_req    (mem_req),
    .mem_rvalid (mem_rvalid)
);

/* bench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam int MAX_VEC = 64;
    localparam int COLS    = 5;

    logic                    clk;
    logic                    rst;
    logic                    req;
    logic                    we;
    logic                    flush;
    addr_pkg::aligned_addr_t addr;
    cache_pkg::data_t        wdata;
    logic                    busy;
    logic                    resp_valid;
    logic                    resp_hit;
    cache_pkg::data_t        resp_data;
    logic                    mem_req;
    logic                    mem_we;
    logic                    mem_rvalid;
    addr_pkg::aligned_addr_t mem_addr;
    cache_pkg::data_t        mem_wdata;
    cache_pkg::data_t        mem_rdata;

    // Each vector is five words of op, address, write data, expected data and expected hit
    logic [63:0] vec_words [MAX_VEC*COLS];
    int          n_vec;
    int          n_pass;
    int          n_fail;
    int          cycle_count;
    int          timeout_cycles;
    logic        test_ok;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    dcache_top dut_i (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .flush(flush), .busy(busy), .resp_valid(resp_valid), .resp_data(resp_data),
        .resp_hit(resp_hit), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
    );

    mem_model mem_model_i (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
    );

    function automatic string op_name(input logic [63:0] op);
        if (op == 0) return "load";
        if (op == 1) return "store";
        return "flush";
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        test_ok = 1'b0;
    endtask

    // Runs one vector and waits until busy is low again
    task automatic run_op(input int idx);
        logic [63:0]             op;
        addr_pkg::aligned_addr_t a;
        cache_pkg::data_t        wd;
        cache_pkg::data_t        exp_data;
        logic                    exp_hit;
        int                      k;
        int                      n_req;
        int                      n_we;
        int                      n_resp;
        int                      resp_cycle;
        logic                    done;
        op       = vec_words[idx*COLS];
        a        = addr_pkg::aligned_addr_t'(vec_words[idx*COLS+1]);
        wd       = vec_words[idx*COLS+2];
        exp_data = vec_words[idx*COLS+3];
        exp_hit  = vec_words[idx*COLS+4][0];
        test_ok  = 1'b1;
        k        = 0;
        n_req    = 0;
        n_we     = 0;
        n_resp   = 0;
        resp_cycle = -1;
        done     = 1'b0;
        @(posedge clk);
        #1;
        addr  = a;
        wdata = wd;
        req   = (op != 2);
        we    = (op == 1);
        flush = (op == 2);
        while (!done) begin
            @(negedge clk);
            if (mem_req) begin
                n_req++;
                if (mem_addr !== a) report_mismatch("mem_addr", a, mem_addr);
            end
            if (mem_we) begin
                n_we++;
                if (mem_addr !== a) report_mismatch("mem_addr", a, mem_addr);
                if (mem_wdata !== wd) report_mismatch("mem_wdata", wd, mem_wdata);
            end
            if (resp_valid) begin
                n_resp++;
                resp_cycle = k;
                if (resp_data !== exp_data) report_mismatch("resp_data", exp_data, resp_data);
                if (resp_hit !== exp_hit) report_mismatch("resp_hit", exp_hit, resp_hit);
            end
            if (k >= 1 && busy === 1'b0) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                req   = 1'b0;
                we    = 1'b0;
                flush = 1'b0;
                k++;
            end
        end
        if (op == 0) begin
            if (n_resp == 0) begin
                $display("Load of %h ended without a response at t=%0t", a, $time);
                test_ok = 1'b0;
            end
            if (n_resp > 1) report_mismatch("resp_valid count", 1, n_resp);
            if (n_req != (exp_hit ? 0 : 1)) report_mismatch("mem_req count", !exp_hit, n_req);
            if (exp_hit && resp_cycle != 2) report_mismatch("hit latency", 2, resp_cycle);
            if (n_we != 0) report_mismatch("mem_we count", 0, n_we);
        end else begin
            if (n_resp != 0) report_mismatch("resp_valid count", 0, n_resp);
            if (n_req != 0) report_mismatch("mem_req count", 0, n_req);
            if (n_we != (op == 1)) report_mismatch("mem_we count", op == 1, n_we);
            if (op == 1 && k != 2) report_mismatch("store busy end cycle", 2, k);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        req   = 1'b0;
        we    = 1'b0;
        flush = 1'b0;
        addr  = '0;
        wdata = '0;
        n_pass = 0;
        n_fail = 0;
        cycle_count = 0;
        for (int i = 0; i < MAX_VEC*COLS; i++) begin
            vec_words[i] = '1;
        end
        $readmemh("bench/dcache_vectors.txt", vec_words);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_words[n_vec*COLS] != '1) begin
            n_vec++;
        end
        // Worst case per vector plus the reset phase
        timeout_cycles = n_vec * 12 + 20;
        if (n_vec == 0) begin
            $display("No vectors could be read from bench/dcache_vectors.txt");
            n_fail++;
        end

        // Outputs stay quiet through reset and just after it
        test_ok = 1'b1;
        @(posedge clk);
        repeat (10) begin
            @(negedge clk);
            if (busy !== 1'b0) report_mismatch("busy", 0, busy);
            if (resp_valid !== 1'b0) report_mismatch("resp_valid", 0, resp_valid);
            if (mem_req !== 1'b0) report_mismatch("mem_req", 0, mem_req);
            if (mem_we !== 1'b0) report_mismatch("mem_we", 0, mem_we);
        end
        if (test_ok) n_pass++;
        else n_fail++;
        $display("test reset quiet state: %s", test_ok ? "ok" : "failed");

        for (int i = 0; i < n_vec; i++) begin
            run_op(i);
            if (test_ok) n_pass++;
            else n_fail++;
            $display("test %0d %s %h: %s", i, op_name(vec_words[i*COLS]),
                     vec_words[i*COLS+1][39:0], test_ok ? "ok" : "failed");
        end

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* bench/dcache_vectors.txt */
// Columns: op (0 load, 1 store, 2 flush), word address, write data,
// expected load data, expected hit flag
// Cold miss after reset, then the same load hits
0 0000000010 0 A5C30F1E96B47D38 0
0 0000000010 0 A5C30F1E96B47D38 1
// Index 0x10 shared by two tags, every load evicts the other
0 0000000110 0 A5C30F1E96B47C38 0
0 0000000010 0 A5C30F1E96B47D38 0
0 0000000110 0 A5C30F1E96B47C38 0
// Store allocates and writes through, the next load hits
1 0000000020 0123456789ABCDEF 0 0
0 0000000020 0 0123456789ABCDEF 1
// Store over a line that holds the other tag
1 0000000010 FEDCBA9876543210 0 0
0 0000000010 0 FEDCBA9876543210 1
// Flush, then loads refill the stored values from memory
2 0 0 0 0
0 0000000020 0 0123456789ABCDEF 0
0 0000000010 0 FEDCBA9876543210 0
0 0000000010 0 FEDCBA9876543210 1
// High tag bits on another line
0 1000000030 0 A5C30F0E96B47D18 0
0 1000000030 0 A5C30F0E96B47D18 1

/* verilog.f */
+incdir+common
common/addr_pkg.sv
common/cache_pkg.sv
cache/line_store.sv
cache/refill_ctrl.sv
design/dcache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - common
    files:
      - common/addr_pkg.sv
      - common/cache_pkg.sv
      - cache/line_store.sv
      - cache/refill_ctrl.sv
      - design/dcache_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/clk_gen.sv
      - bench/mem_model.sv
      - bench/dcache_properties.sv
      - bench/dcache_tb.sv
